/* elevator_pkg.sv */
package elevator_pkg;

    // Building and car sizing
    localparam int num_floors    = 4;
    localparam int queue_depth   = 8;  // Slots in the car
    localparam int dock_depth    = 4;  // Dock FIFO entries, also the sender's start credit
    localparam int travel_cycles = 3;  // Cycles spent per floor of travel

    // Floor number, wide enough for every floor of the shaft
    typedef logic [$clog2(num_floors)-1:0] floor_t;

    // Object kind, not interpreted by the elevator
    typedef logic [1:0] kind_t;

    // One object as it moves from dock to car to delivery
    typedef struct packed {
        kind_t  kind;
        floor_t dest;
    } cargo_t;

    // Controller states
    typedef enum logic [1:0] {
        idle,
        unload,   // Dropping off objects for the current floor
        load,     // Moving objects from the dock into the car
        travel    // Car on its way to the oldest object's floor
    } ctrl_state_t;

endpackage

/* elevator_top.f */
elevator_pkg.sv
verilog/dock_buffer.sv
verilog/car_queue.sv
verilog/floor_drive.sv
verilog/elevator_control.sv
verilog/elevator_top.sv
tb/clock_gen.sv
tb/elevator_assert.sv
tb/elevator_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module elevator_tb -f elevator_top.f \
    -Mdir obj_dir -o elevator_sim \
    && ./obj_dir/elevator_sim \
    || { echo "Simulation did not complete successfully"; exit 1; }

/* tb/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic clear
);

    initial begin
        clk   = 1'b0;
        clear = 1'b1;  // Held through the first two rising edges
        repeat (2) @(posedge clk);
        clear <= 1'b0;
    end

    always #5 clk = ~clk;  // 10 ns period

endmodule

/* tb/elevator_assert.sv */
`timescale 1ns/1ps

module elevator_assert (
    input logic clk,
    input logic clear,
    input logic dock_valid,
    input logic dock_credit,
    input logic deliver_valid,
    input logic moving
);

    int in_dock;  // Sent but not yet credited back
    int pending;  // Credited back but not yet delivered

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            in_dock <= 0;
            pending <= 0;
        end else begin
            in_dock <= in_dock + int'(dock_valid) - int'(dock_credit);
            pending <= pending + int'(dock_credit) - int'(deliver_valid);
        end
    end

    // A credit only comes back for an object that is in the dock
    credit_has_object: assert property (@(posedge clk) disable iff (clear)
        dock_credit |-> in_dock > 0)
        else $error("Credit returned with no object outstanding in the dock");

    no_delivery_in_motion: assert property (@(posedge clk) disable iff (clear)
        deliver_valid |-> !moving)
        else $error("Delivery while the car is moving");

    pending_in_bounds: assert property (@(posedge clk) disable iff (clear)
        pending >= 0 && pending <= elevator_pkg::queue_depth)
        else $error("Pending deliveries outside the car capacity");

endmodule

bind elevator_top elevator_assert i_elevator_assert (
    .clk           (clk),
    .clear         (clear),
    .dock_valid    (dock_valid),
    .dock_credit   (dock_credit),
    .deliver_valid (deliver_valid),
    .moving        (moving)
);

/* tb/elevator_tb.sv */
`timescale 1ns/1ps

module elevator_tb;

    typedef struct packed {
        elevator_pkg::kind_t  kind;
        elevator_pkg::floor_t dest;
        logic [3:0]           gap;  // Idle cycles before the send
    } stim_t;

    localparam int n_stim          = 16;
    localparam int lead_zero       = 3;  // First entries go to floor 0 with the car at rest
    localparam int credit_timeout  = 200;
    localparam int deliver_timeout = 3000;

    // Kind, destination, gap
    localparam stim_t stim_tab [n_stim] = '{
        '{2'd1, 2'd0, 4'd0},
        '{2'd2, 2'd0, 4'd0},
        '{2'd3, 2'd0, 4'd1},
        '{2'd0, 2'd2, 4'd0},
        '{2'd1, 2'd3, 4'd2},
        '{2'd2, 2'd1, 4'd0},
        '{2'd3, 2'd2, 4'd0},
        '{2'd0, 2'd0, 4'd0},
        '{2'd1, 2'd1, 4'd0},
        '{2'd2, 2'd3, 4'd0},
        '{2'd3, 2'd3, 4'd0},
        '{2'd0, 2'd1, 4'd4},
        '{2'd1, 2'd2, 4'd0},
        '{2'd2, 2'd0, 4'd0},
        '{2'd3, 2'd1, 4'd1},
        '{2'd0, 2'd3, 4'd0}
    };

    logic                 clk;
    logic                 clear;
    logic                 dock_valid;
    elevator_pkg::cargo_t dock_cargo;
    logic                 dock_credit;
    logic                 deliver_valid;
    elevator_pkg::cargo_t deliver_cargo;
    elevator_pkg::floor_t deliver_floor;
    logic                 moving;

    logic [31:0] rng_state = 32'h6973ba70;
    int          sent_count = 0;
    int          credits_back = 0;
    int          delivered = 0;
    logic        car_moved = 1'b0;
    int          exp_q [elevator_pkg::num_floors][$];  // Table indices, one FIFO per floor

    clock_gen i_clock_gen (
        .clk   (clk),
        .clear (clear)
    );

    elevator_top i_elevator_top (
        .clk           (clk),
        .clear         (clear),
        .dock_valid    (dock_valid),
        .dock_cargo    (dock_cargo),
        .dock_credit   (dock_credit),
        .deliver_valid (deliver_valid),
        .deliver_cargo (deliver_cargo),
        .deliver_floor (deliver_floor),
        .moving        (moving)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int credits_left();
        return elevator_pkg::dock_depth + credits_back - sent_count;
    endfunction

    task automatic hold_for_reset();
        int waited;
        waited = 0;
        while (clear !== 1'b0) begin
            @(posedge clk);
            waited++;
            assert (waited < 10) else fail_run("Reset was never released");
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            dock_valid <= 1'b0;
        end
    endtask

    // Sends one table entry once a credit is available
    task automatic send_object(input int idx);
        int waited;
        waited = 0;
        @(posedge clk);
        while (credits_left() == 0) begin
            dock_valid <= 1'b0;
            waited++;
            assert (waited < credit_timeout)
                else fail_run($sformatf("No dock credit came back for object %0d", idx));
            @(posedge clk);
        end
        dock_valid <= 1'b1;
        dock_cargo <= '{kind: stim_tab[idx].kind, dest: stim_tab[idx].dest};
        sent_count++;
        exp_q[stim_tab[idx].dest].push_back(idx);
    endtask

    task automatic check_delivery();
        int idx;
        assert (exp_q[deliver_cargo.dest].size() > 0)
            else fail_run($sformatf("Object for floor %0d delivered at %0t but none was owed",
                                    deliver_cargo.dest, $time));
        idx = exp_q[deliver_cargo.dest].pop_front();
        assert (deliver_floor == stim_tab[idx].dest)
            else fail_run($sformatf("Mismatch at %0t: object for floor %0d delivered at floor %0d",
                                    $time, stim_tab[idx].dest, deliver_floor));
        // Arrival order within a floor
        assert (deliver_cargo.kind == stim_tab[idx].kind)
            else fail_run($sformatf("Mismatch at %0t: floor %0d expected kind %0d, got %0d",
                                    $time, deliver_cargo.dest, stim_tab[idx].kind,
                                    deliver_cargo.kind));
        if (idx < lead_zero) begin
            assert (!car_moved && !moving)
                else fail_run($sformatf("Object %0d for floor 0 waited for the car to move", idx));
        end
        delivered++;
    endtask

    task automatic drain_deliveries();
        int waited;
        waited = 0;
        while (delivered < n_stim || credits_back < sent_count) begin
            @(posedge clk);
            waited++;
            assert (waited < deliver_timeout)
                else fail_run($sformatf("Only %0d of %0d objects delivered before the timeout",
                                        delivered, n_stim));
        end
    endtask

    // Outputs settle by the falling edge
    always @(negedge clk) begin
        if (!clear) begin
            if (moving) begin
                car_moved = 1'b1;
            end
            if (dock_credit) begin
                credits_back++;
            end
            if (deliver_valid) begin
                check_delivery();
            end
        end
    end

    initial begin
        dock_valid = 1'b0;
        dock_cargo = '0;
        hold_for_reset();
        for (int i = 0; i < n_stim; i++) begin
            idle_cycles(int'(stim_tab[i].gap) + int'((lcg_next() >> 16) % 32'd3));
            send_object(i);
        end
        @(posedge clk);
        dock_valid <= 1'b0;
        drain_deliveries();
        assert (credits_back == n_stim)
            else fail_run($sformatf("Mismatch at %0t: %0d credits returned for %0d objects",
                                    $time, credits_back, n_stim));
        $display("all tests passed");
        $finish;
    end

endmodule

/* verilog/car_queue.sv */
`timescale 1ns/1ps

module car_queue (
    input  logic                 clk,
    input  logic                 clear,
    input  logic                 push,
    input  elevator_pkg::cargo_t push_cargo,
    input  logic                 unload,
    input  elevator_pkg::floor_t floor,
    output logic                 match,
    output elevator_pkg::cargo_t unload_cargo,
    output elevator_pkg::floor_t oldest_dest,
    output logic                 full,
    output logic                 empty
);

    typedef logic [$clog2(elevator_pkg::queue_depth)-1:0] idx_t;

    // Slots stay packed toward 0, slot 0 holds the oldest object
    logic [elevator_pkg::queue_depth-1:0] valid;
    elevator_pkg::cargo_t                 cargo [elevator_pkg::queue_depth];

    idx_t hit_idx;   // Oldest slot bound for this floor
    idx_t free_idx;  // Tail, first empty slot
    logic do_unload;
    logic do_push;

    // Scan from the top so the lowest index wins
    always_comb begin
        match    = 1'b0;
        hit_idx  = '0;
        free_idx = '0;
        for (int i = elevator_pkg::queue_depth - 1; i >= 0; i--) begin
            if (valid[i] && cargo[i].dest == floor) begin
                match   = 1'b1;
                hit_idx = idx_t'(i);
            end
            if (!valid[i]) begin
                free_idx = idx_t'(i);
            end
        end
    end

    assign do_unload = unload && match;
    assign do_push   = push && !full && !do_unload;

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            valid <= '0;
        end else if (do_unload) begin
            for (int i = 0; i < elevator_pkg::queue_depth - 1; i++) begin
                if (idx_t'(i) >= hit_idx) begin
                    valid[i] <= valid[i+1];
                end
            end
            valid[elevator_pkg::queue_depth-1] <= 1'b0;  // Tail slot frees up
        end else if (do_push) begin
            valid[free_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_unload) begin
            // Close the gap left by the leaving object
            for (int i = 0; i < elevator_pkg::queue_depth - 1; i++) begin
                if (idx_t'(i) >= hit_idx) begin
                    cargo[i] <= cargo[i+1];
                end
            end
        end else if (do_push) begin
            cargo[free_idx] <= push_cargo;
        end
    end

    assign unload_cargo = cargo[hit_idx];
    assign oldest_dest  = cargo[0].dest;
    assign full         = valid[elevator_pkg::queue_depth-1];
    assign empty        = !valid[0];

endmodule

/* verilog/dock_buffer.sv */
`timescale 1ns/1ps

module dock_buffer (
    input  logic                 clk,
    input  logic                 clear,
    input  logic                 dock_valid,
    input  elevator_pkg::cargo_t dock_cargo,
    input  logic                 pop,
    output elevator_pkg::cargo_t head,
    output logic                 empty,
    output logic                 dock_credit
);

    elevator_pkg::cargo_t mem [elevator_pkg::dock_depth];

    logic [$clog2(elevator_pkg::dock_depth)-1:0] wr_ptr;
    logic [$clog2(elevator_pkg::dock_depth)-1:0] rd_ptr;
    logic [$clog2(elevator_pkg::dock_depth):0]   count;

    // Sender credits keep the FIFO from overflowing
    always_ff @(posedge clk) begin
        if (dock_valid) begin
            mem[wr_ptr] <= dock_cargo;
        end
    end

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            dock_credit <= 1'b0;
        end else begin
            dock_credit <= pop;  // One credit back per entry leaving
            if (dock_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({dock_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);

endmodule

/* verilog/elevator_control.sv */
`timescale 1ns/1ps

module elevator_control (
    input  logic                 clk,
    input  logic                 clear,
    input  logic                 dock_empty,
    input  elevator_pkg::cargo_t dock_head,
    input  logic                 q_match,
    input  logic                 q_full,
    input  logic                 q_empty,
    input  elevator_pkg::floor_t oldest_dest,
    input  elevator_pkg::floor_t floor,
    input  logic                 arrived,
    input  elevator_pkg::cargo_t unload_cargo,
    output logic                 dock_pop,
    output logic                 q_push,
    output logic                 q_unload,
    output logic                 go,
    output elevator_pkg::floor_t target,
    output logic                 deliver_valid,
    output elevator_pkg::cargo_t deliver_cargo,
    output elevator_pkg::floor_t deliver_floor
);

    elevator_pkg::ctrl_state_t state;
    elevator_pkg::ctrl_state_t next_state;
    elevator_pkg::ctrl_state_t settle_state;
    logic                      depart;

    // Next step once the car is done loading or unloading
    always_comb begin
        if (q_empty) begin
            settle_state = elevator_pkg::idle;
        end else if (q_match) begin
            settle_state = elevator_pkg::unload;  // Something is for this floor
        end else begin
            settle_state = elevator_pkg::travel;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            elevator_pkg::idle: begin
                if (!dock_empty) begin
                    next_state = elevator_pkg::load;
                end else begin
                    next_state = settle_state;
                end
            end
            elevator_pkg::unload: begin
                if (!q_match) begin
                    if (!dock_empty && !q_full) begin
                        next_state = elevator_pkg::load;
                    end else begin
                        next_state = settle_state;
                    end
                end
            end
            elevator_pkg::load: begin
                if (dock_empty || q_full) begin
                    next_state = settle_state;
                end
            end
            elevator_pkg::travel: begin
                if (arrived) begin
                    next_state = elevator_pkg::unload;
                end
            end
            default: next_state = elevator_pkg::idle;
        endcase
    end

    assign depart = (next_state == elevator_pkg::travel) && (state != elevator_pkg::travel);

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            state  <= elevator_pkg::idle;
            go     <= 1'b0;
            target <= '0;
        end else begin
            state <= next_state;
            go    <= depart;  // Single pulse on entering travel
            if (depart) begin
                target <= oldest_dest;
            end
        end
    end

    assign dock_pop = (state == elevator_pkg::load) && !dock_empty && !q_full;
    assign q_push   = dock_pop;
    assign q_unload = (state == elevator_pkg::unload) && q_match;

    // Delivery shows the slot before the edge removes it
    assign deliver_valid = q_unload;
    assign deliver_cargo = unload_cargo;
    assign deliver_floor = floor;

endmodule

/* verilog/elevator_top.sv */
`timescale 1ns/1ps

module elevator_top (
    input  logic                 clk,
    input  logic                 clear,
    input  logic                 dock_valid,
    input  elevator_pkg::cargo_t dock_cargo,
    output logic                 dock_credit,
    output logic                 deliver_valid,
    output elevator_pkg::cargo_t deliver_cargo,
    output elevator_pkg::floor_t deliver_floor,
    output logic                 moving
);

    logic                 dock_pop;
    logic                 dock_empty;
    elevator_pkg::cargo_t dock_head;
    logic                 q_push;
    logic                 q_unload;
    logic                 q_match;
    logic                 q_full;
    logic                 q_empty;
    elevator_pkg::floor_t oldest_dest;
    elevator_pkg::cargo_t unload_cargo;
    logic                 go;
    elevator_pkg::floor_t target;
    elevator_pkg::floor_t floor;
    logic                 arrived;

    dock_buffer i_dock_buffer (
        .clk         (clk),
        .clear       (clear),
        .dock_valid  (dock_valid),
        .dock_cargo  (dock_cargo),
        .pop         (dock_pop),
        .head        (dock_head),
        .empty       (dock_empty),
        .dock_credit (dock_credit)
    );

    car_queue i_car_queue (
        .clk          (clk),
        .clear        (clear),
        .push         (q_push),
        .push_cargo   (dock_head),  // Dock head goes straight into the car
        .unload       (q_unload),
        .floor        (floor),
        .match        (q_match),
        .unload_cargo (unload_cargo),
        .oldest_dest  (oldest_dest),
        .full         (q_full),
        .empty        (q_empty)
    );

    floor_drive i_floor_drive (
        .clk     (clk),
        .clear   (clear),
        .go      (go),
        .target  (target),
        .floor   (floor),
        .arrived (arrived),
        .moving  (moving)
    );

    elevator_control i_elevator_control (
        .clk           (clk),
        .clear         (clear),
        .dock_empty    (dock_empty),
        .dock_head     (dock_head),
        .q_match       (q_match),
        .q_full        (q_full),
        .q_empty       (q_empty),
        .oldest_dest   (oldest_dest),
        .floor         (floor),
        .arrived       (arrived),
        .unload_cargo  (unload_cargo),
        .dock_pop      (dock_pop),
        .q_push        (q_push),
        .q_unload      (q_unload),
        .go            (go),
        .target        (target),
        .deliver_valid (deliver_valid),
        .deliver_cargo (deliver_cargo),
        .deliver_floor (deliver_floor)
    );

endmodule

/* verilog/floor_drive.sv */
`timescale 1ns/1ps

module floor_drive (
    input  logic                 clk,
    input  logic                 clear,
    input  logic                 go,
    input  elevator_pkg::floor_t target,
    output elevator_pkg::floor_t floor,
    output logic                 arrived,
    output logic                 moving
);

    typedef logic [$clog2(elevator_pkg::travel_cycles)-1:0] timer_t;

    elevator_pkg::floor_t goal;        // Latched target
    elevator_pkg::floor_t next_floor;
    timer_t               timer;
    logic                 step;

    assign step = moving && (timer == timer_t'(elevator_pkg::travel_cycles - 1));

    // One floor toward the goal
    always_comb begin
        next_floor = floor;
        if (goal > floor) begin
            next_floor = floor + 1'b1;
        end else if (goal < floor) begin
            next_floor = floor - 1'b1;
        end
    end

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            floor   <= '0;
            goal    <= '0;
            timer   <= '0;
            moving  <= 1'b0;
            arrived <= 1'b0;
        end else begin
            arrived <= 1'b0;
            if (go) begin
                goal    <= target;
                timer   <= '0;
                moving  <= (target != floor);
                arrived <= (target == floor);  // Already there
            end else if (step) begin
                timer <= '0;
                floor <= next_floor;
                if (next_floor == goal) begin
                    moving  <= 1'b0;
                    arrived <= 1'b1;
                end
            end else if (moving) begin
                timer <= timer + 1'b1;
            end
        end
    end

endmodule
